//--- hw/fetch_aligner.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_aligner (
    input  logic                   clk,
    input  logic                   reset_i,

    // flush and restart address
    input  logic                   flush_i,
    input  fetch_pkg::fetch_addr_t flush_addr_i,

    // any raw redirect this cycle
    input  logic                   redirect_any_i,

    // buffer slots
    input  fetch_pkg::line_t [`FETCH_SLOTS-1:0] slot_line_i,
    input  logic [`FETCH_SLOTS-1:0]             slot_valid_i,

    // decode side
    input  fetch_pkg::len_t        length_i,
    input  logic                   stall_i,
    output fetch_pkg::packet_t     packet_o,
    output fetch_pkg::fetch_addr_t packet_addr_o,
    output logic                   packet_valid_o,

    // half release to the buffer
    output logic                   release_o,
    output logic                   release_half_o
);

    fetch_pkg::fetch_addr_t fip_q;
    fetch_pkg::fetch_addr_t fip_next;
    fetch_pkg::bip_t        bip;
    logic [1:0]             cur_slot;
    logic [1:0]             next_slot;
    logic [2*`FETCH_WINDOW_BITS-1:0] window2;
    logic                   lines_valid;
    logic                   consume;

    //////////////////////////////
    // pointer and slot lookup
    //////////////////////////////

    assign bip       = fip_q[`FETCH_BIP_BITS-1:0];
    assign cur_slot  = bip[`FETCH_BIP_BITS-1 -: 2];

    // wraps from slot 3 back to slot 0
    assign next_slot = cur_slot + 2'd1;

    // packet may reach into the following line
    assign lines_valid = slot_valid_i[cur_slot] & slot_valid_i[next_slot];

    // a redirect cycle never hands out a packet
    assign packet_valid_o = lines_valid & ~redirect_any_i;

    //////////////////////////////
    // rotation
    //////////////////////////////

    // window doubled so the select wraps around the top
    assign window2  = {slot_line_i, slot_line_i};
    assign packet_o = window2[{bip, 3'b000} +: `FETCH_LINE_BITS];

    assign packet_addr_o = fip_q;

    //////////////////////////////
    // advance and release
    //////////////////////////////

    assign consume  = packet_valid_o & ~stall_i;
    assign fip_next = fip_q + fetch_pkg::fetch_addr_t'(length_i);

    // bit 5 flips when the pointer crosses into the other half
    assign release_o      = consume & (fip_next[`FETCH_PAIR_LSB] != fip_q[`FETCH_PAIR_LSB]);
    assign release_half_o = fip_q[`FETCH_PAIR_LSB];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fip_q <= '0;
        end else if (flush_i) begin
            fip_q <= flush_addr_i;
        end else if (consume) begin
            fip_q <= fip_next;
        end
    end

endmodule

//--- hw/fetch_ibuff.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_ibuff (
    input  logic                   clk,
    input  logic                   reset_i,

    // flush from the fetcher
    input  logic                   flush_i,

    // refill, one pair per strobe
    input  logic                   fill_strobe_i,
    input  logic                   fill_half_i,
    input  fetch_pkg::line_t       fill_even_i,
    input  fetch_pkg::line_t       fill_odd_i,

    // release from the aligner
    input  logic                   release_i,
    input  logic                   release_half_i,

    // slot contents
    output fetch_pkg::line_t [`FETCH_SLOTS-1:0] slot_line_o,
    output logic [`FETCH_SLOTS-1:0]             slot_valid_o,
    output logic [`FETCH_HALVES-1:0]            half_valid_o
);

    fetch_pkg::line_t [`FETCH_SLOTS-1:0] line_q;
    logic [`FETCH_SLOTS-1:0]             valid_q;

    //////////////////////////////
    // line storage
    //////////////////////////////

    // even line to slot 2h, odd line to slot 2h+1
    always_ff @(posedge clk) begin
        if (fill_strobe_i) begin
            line_q[{fill_half_i, 1'b0}] <= fill_even_i;
            line_q[{fill_half_i, 1'b1}] <= fill_odd_i;
        end
    end

    //////////////////////////////
    // valid bits
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // flush beats fill and release
            valid_q <= '0;
        end else begin
            for (int h = 0; h < `FETCH_HALVES; h++) begin
                if (release_i && (release_half_i == h[0])) begin
                    valid_q[2*h]   <= 1'b0;
                    valid_q[2*h+1] <= 1'b0;
                end else if (fill_strobe_i && (fill_half_i == h[0])) begin
                    valid_q[2*h]   <= 1'b1;
                    valid_q[2*h+1] <= 1'b1;
                end
            end
        end
    end

    // half counts as busy while any of its lines is held
    always_comb begin
        for (int h = 0; h < `FETCH_HALVES; h++) begin
            half_valid_o[h] = valid_q[2*h] | valid_q[2*h+1];
        end
    end

    assign slot_line_o  = line_q;
    assign slot_valid_o = valid_q;

endmodule

//--- hw/fetch_line_fetcher.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_line_fetcher (
    input  logic                   clk,
    input  logic                   reset_i,

    // redirect sources
    input  logic                   init_i,
    input  fetch_pkg::fetch_addr_t init_addr_i,
    input  logic                   resteer_i,
    input  fetch_pkg::fetch_addr_t resteer_addr_i,
    input  logic                   branch_taken_i,
    input  fetch_pkg::fetch_addr_t branch_target_i,

    // occupancy from the buffer
    input  logic [`FETCH_HALVES-1:0] half_valid_i,

    // instruction memory
    input  logic                   imem_ack_i,
    input  fetch_pkg::line_t       imem_even_line_i,
    input  fetch_pkg::line_t       imem_odd_line_i,
    output logic                   imem_req_o,
    output fetch_pkg::pair_addr_t  imem_pair_addr_o,

    // flush to buffer and aligner
    output logic                   flush_o,
    output fetch_pkg::fetch_addr_t flush_addr_o,

    // refill to buffer
    output logic                   fill_strobe_o,
    output logic                   fill_half_o,
    output fetch_pkg::line_t       fill_even_o,
    output fetch_pkg::line_t       fill_odd_o
);

    logic                   redirect;
    fetch_pkg::fetch_addr_t redirect_addr;
    fetch_pkg::pair_addr_t  pair_q;
    logic                   half_q;
    logic                   active_q;
    logic                   busy_q;
    logic                   stale_q;
    logic                   req;
    logic                   fill_ok;

    //////////////////////////////
    // redirect select
    //////////////////////////////

    assign redirect = init_i | resteer_i | branch_taken_i;

    // init wins, then resteer, then taken branch
    always_comb begin
        if (init_i) begin
            redirect_addr = init_addr_i;
        end else if (resteer_i) begin
            redirect_addr = resteer_addr_i;
        end else begin
            redirect_addr = branch_target_i;
        end
    end

    assign flush_o      = redirect;
    assign flush_addr_o = redirect_addr;

    //////////////////////////////
    // request and return
    //////////////////////////////

    // one request at a time, only into a free half
    assign req = active_q & ~busy_q & ~redirect & ~half_valid_i[half_q];

    // responses to a flushed request are thrown away
    assign fill_ok = imem_ack_i & busy_q & ~stale_q & ~redirect;

    assign imem_req_o       = req;
    assign imem_pair_addr_o = pair_q;

    assign fill_strobe_o = fill_ok;
    assign fill_half_o   = half_q;
    assign fill_even_o   = imem_even_line_i;
    assign fill_odd_o    = imem_odd_line_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            active_q <= 1'b0;
            busy_q   <= 1'b0;
            stale_q  <= 1'b0;
        end else begin
            // idle until the first redirect
            if (redirect) begin
                active_q <= 1'b1;
            end

            if (req) begin
                busy_q <= 1'b1;
            end else if (imem_ack_i) begin
                busy_q <= 1'b0;
            end

            if (imem_ack_i) begin
                stale_q <= 1'b0;
            end else if (redirect && busy_q) begin
                stale_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // pair sequencing
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pair_q <= '0;
            half_q <= 1'b0;
        end else if (redirect) begin
            pair_q <= redirect_addr[`FETCH_ADDR_BITS-1:`FETCH_PAIR_LSB];
            half_q <= redirect_addr[`FETCH_PAIR_LSB];
        end else if (fill_ok) begin
            // next pair lands in the other half
            pair_q <= pair_q + 1'b1;
            half_q <= ~half_q;
        end
    end

endmodule

//--- hw/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// address and line geometry
`define FETCH_ADDR_BITS    32
`define FETCH_LINE_BYTES   16
`define FETCH_LINE_BITS    (`FETCH_LINE_BYTES * 8)

// buffer holds two halves, each one even/odd pair
`define FETCH_SLOTS        4
`define FETCH_HALVES       (`FETCH_SLOTS / 2)
`define FETCH_WINDOW_BYTES (`FETCH_SLOTS * `FETCH_LINE_BYTES)
`define FETCH_WINDOW_BITS  (`FETCH_WINDOW_BYTES * 8)

// byte pointer into the window, bit 5 picks the half
`define FETCH_BIP_BITS     6
`define FETCH_PAIR_LSB     5

// longest instruction decode can report
`define FETCH_MAX_LEN      15

`endif

//--- hw/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // byte address of the fetch stream
    typedef logic [`FETCH_ADDR_BITS-1:0] fetch_addr_t;

    // one 16-byte line, byte 0 in bits 7:0
    typedef logic [`FETCH_LINE_BITS-1:0] line_t;

    // packet to decode, same byte order as a line
    typedef logic [`FETCH_LINE_BITS-1:0] packet_t;

    // 32-byte aligned pair, address bits 31:5
    typedef logic [`FETCH_ADDR_BITS-1:`FETCH_PAIR_LSB] pair_addr_t;

    // pointer into the 64-byte window
    // bit 5 is the half, bit 4 even or odd line
    typedef logic [`FETCH_BIP_BITS-1:0] bip_t;

    // decode length, wide enough for the longest instruction
    typedef logic [$clog2(`FETCH_MAX_LEN + 1)-1:0] len_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_top (
    input  logic                   clk,
    input  logic                   reset_i,

    // redirect sources
    input  logic                   init_i,
    input  fetch_pkg::fetch_addr_t init_addr_i,
    input  logic                   resteer_i,
    input  fetch_pkg::fetch_addr_t resteer_addr_i,
    input  logic                   branch_taken_i,
    input  fetch_pkg::fetch_addr_t branch_target_i,

    // instruction memory
    input  logic                   imem_ack_i,
    input  fetch_pkg::line_t       imem_even_line_i,
    input  fetch_pkg::line_t       imem_odd_line_i,
    output logic                   imem_req_o,
    output fetch_pkg::pair_addr_t  imem_pair_addr_o,

    // decode
    input  fetch_pkg::len_t        length_i,
    input  logic                   stall_i,
    output fetch_pkg::packet_t     packet_o,
    output fetch_pkg::fetch_addr_t packet_addr_o,
    output logic                   packet_valid_o
);

    logic                   flush;
    fetch_pkg::fetch_addr_t flush_addr;
    logic                   redirect_any;
    logic                   fill_strobe;
    logic                   fill_half;
    fetch_pkg::line_t       fill_even;
    fetch_pkg::line_t       fill_odd;
    logic                   release_strobe;
    logic                   release_half;
    logic [`FETCH_HALVES-1:0]            half_valid;
    fetch_pkg::line_t [`FETCH_SLOTS-1:0] slot_line;
    logic [`FETCH_SLOTS-1:0]             slot_valid;

    // only masks packet valid, the flush itself comes from the fetcher
    assign redirect_any = init_i | resteer_i | branch_taken_i;

    fetch_line_fetcher fetch_line_fetcher_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .init_i           (init_i),
        .init_addr_i      (init_addr_i),
        .resteer_i        (resteer_i),
        .resteer_addr_i   (resteer_addr_i),
        .branch_taken_i   (branch_taken_i),
        .branch_target_i  (branch_target_i),
        .half_valid_i     (half_valid),
        .imem_ack_i       (imem_ack_i),
        .imem_even_line_i (imem_even_line_i),
        .imem_odd_line_i  (imem_odd_line_i),
        .imem_req_o       (imem_req_o),
        .imem_pair_addr_o (imem_pair_addr_o),
        .flush_o          (flush),
        .flush_addr_o     (flush_addr),
        .fill_strobe_o    (fill_strobe),
        .fill_half_o      (fill_half),
        .fill_even_o      (fill_even),
        .fill_odd_o       (fill_odd)
    );

    fetch_ibuff fetch_ibuff_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush),
        .fill_strobe_i  (fill_strobe),
        .fill_half_i    (fill_half),
        .fill_even_i    (fill_even),
        .fill_odd_i     (fill_odd),
        .release_i      (release_strobe),
        .release_half_i (release_half),
        .slot_line_o    (slot_line),
        .slot_valid_o   (slot_valid),
        .half_valid_o   (half_valid)
    );

    fetch_aligner fetch_aligner_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .flush_i        (flush),
        .flush_addr_i   (flush_addr),
        .redirect_any_i (redirect_any),
        .slot_line_i    (slot_line),
        .slot_valid_i   (slot_valid),
        .length_i       (length_i),
        .stall_i        (stall_i),
        .packet_o       (packet_o),
        .packet_addr_o  (packet_addr_o),
        .packet_valid_o (packet_valid_o),
        .release_o      (release_strobe),
        .release_half_o (release_half)
    );

endmodule

//--- sim.f
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_line_fetcher.sv
hw/fetch_ibuff.sv
hw/fetch_aligner.sv
hw/fetch_top.sv
test/fetch_tb.sv

//--- test/fetch_tb.sv
`timescale 1ns/100ps
`include "fetch_macros.svh"

module fetch_tb;

    localparam int unsigned SEED       = 32'h8f0f6944;
    localparam int          RAND_CYCLES = 8000;
    localparam int          WAIT_LIMIT  = 20;
    localparam int          MIN_CONSUMED = 1000;

    logic                   clk;
    logic                   reset_i;
    logic                   init_i;
    fetch_pkg::fetch_addr_t init_addr_i;
    logic                   resteer_i;
    fetch_pkg::fetch_addr_t resteer_addr_i;
    logic                   branch_taken_i;
    fetch_pkg::fetch_addr_t branch_target_i;
    logic                   imem_ack_i;
    fetch_pkg::line_t       imem_even_line_i;
    fetch_pkg::line_t       imem_odd_line_i;
    logic                   imem_req_o;
    fetch_pkg::pair_addr_t  imem_pair_addr_o;
    fetch_pkg::len_t        length_i;
    logic                   stall_i;
    fetch_pkg::packet_t     packet_o;
    fetch_pkg::fetch_addr_t packet_addr_o;
    logic                   packet_valid_o;

    // reference model state
    fetch_pkg::fetch_addr_t exp_addr;
    logic                   started;
    logic                   redirect_q;
    logic                   held_ok;
    fetch_pkg::packet_t     held_packet;
    fetch_pkg::fetch_addr_t held_addr;
    int                     idle_cycles;
    int                     consumed;

    fetch_top fetch_top_inst (
        .clk              (clk),
        .reset_i          (reset_i),
        .init_i           (init_i),
        .init_addr_i      (init_addr_i),
        .resteer_i        (resteer_i),
        .resteer_addr_i   (resteer_addr_i),
        .branch_taken_i   (branch_taken_i),
        .branch_target_i  (branch_target_i),
        .imem_ack_i       (imem_ack_i),
        .imem_even_line_i (imem_even_line_i),
        .imem_odd_line_i  (imem_odd_line_i),
        .imem_req_o       (imem_req_o),
        .imem_pair_addr_o (imem_pair_addr_o),
        .length_i         (length_i),
        .stall_i          (stall_i),
        .packet_o         (packet_o),
        .packet_addr_o    (packet_addr_o),
        .packet_valid_o   (packet_valid_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ///////////////////////////////
    // memory contents and model
    ///////////////////////////////

    function automatic logic [7:0] mem_byte(input fetch_pkg::fetch_addr_t a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // sixteen bytes starting at any address
    function automatic fetch_pkg::line_t bytes_from(input fetch_pkg::fetch_addr_t a);
        fetch_pkg::line_t l;
        for (int i = 0; i < `FETCH_LINE_BYTES; i++) begin
            l[8*i +: 8] = mem_byte(a + i);
        end
        return l;
    endfunction

    // answers every request one cycle later
    always @(posedge clk) begin
        if (reset_i) begin
            imem_ack_i <= 1'b0;
        end else begin
            imem_ack_i <= imem_req_o;
            if (imem_req_o) begin
                imem_even_line_i <= bytes_from({imem_pair_addr_o, 5'b00000});
                imem_odd_line_i  <= bytes_from({imem_pair_addr_o, 5'b10000});
            end
        end
    end

    ///////////////////////////////
    // error handling and compares
    ///////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_packet(input fetch_pkg::packet_t got, input fetch_pkg::packet_t exp,
                                input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input fetch_pkg::fetch_addr_t got,
                              input fetch_pkg::fetch_addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pair(input fetch_pkg::pair_addr_t got,
                              input fetch_pkg::pair_addr_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    ///////////////////////////////
    // per-cycle check
    ///////////////////////////////

    // runs mid-cycle, inputs and outputs settled
    task automatic check_cycle;
        logic redirect;
        redirect = init_i | resteer_i | branch_taken_i;
        if (imem_ack_i) begin
            check_flag(imem_req_o, 1'b0, "request while another outstanding");
        end
        if (redirect_q && !redirect) begin
            check_flag(imem_req_o, 1'b1, "request in cycle after redirect");
            check_pair(imem_pair_addr_o, exp_addr[`FETCH_ADDR_BITS-1:`FETCH_PAIR_LSB],
                       "pair address after redirect");
        end
        if (redirect) begin
            check_flag(packet_valid_o, 1'b0, "packet valid in redirect cycle");
            // init first, then resteer, then branch
            if (init_i) begin
                exp_addr = init_addr_i;
            end else if (resteer_i) begin
                exp_addr = resteer_addr_i;
            end else begin
                exp_addr = branch_target_i;
            end
            started     = 1'b1;
            held_ok     = 1'b0;
            idle_cycles = 0;
        end else if (!started) begin
            check_flag(imem_req_o, 1'b0, "request before first redirect");
            check_flag(packet_valid_o, 1'b0, "packet valid before first redirect");
        end else if (packet_valid_o) begin
            if (held_ok) begin
                check_packet(packet_o, held_packet, "packet changed under stall");
                check_addr(packet_addr_o, held_addr, "address changed under stall");
            end
            check_addr(packet_addr_o, exp_addr, "packet address");
            check_packet(packet_o, fetch_pkg::packet_t'(bytes_from(exp_addr)), "packet bytes");
            idle_cycles = 0;
            if (stall_i) begin
                held_ok     = 1'b1;
                held_packet = packet_o;
                held_addr   = packet_addr_o;
            end else begin
                exp_addr = exp_addr + fetch_pkg::fetch_addr_t'(length_i);
                held_ok  = 1'b0;
                consumed++;
            end
        end else begin
            if (held_ok) begin
                check_flag(packet_valid_o, 1'b1, "packet valid dropped under stall");
            end
            idle_cycles++;
            if (idle_cycles > WAIT_LIMIT) begin
                abort_run("timeout: no valid packet arrived within 20 cycles after a redirect");
            end
        end
        redirect_q = redirect;
    endtask

    ///////////////////////////////
    // stimulus
    ///////////////////////////////

    task automatic drive_cycle(input logic init, input fetch_pkg::fetch_addr_t init_addr,
                               input logic resteer, input fetch_pkg::fetch_addr_t resteer_addr,
                               input logic branch, input fetch_pkg::fetch_addr_t target,
                               input logic stall);
        @(posedge clk);
        init_i          <= init;
        init_addr_i     <= init_addr;
        resteer_i       <= resteer;
        resteer_addr_i  <= resteer_addr;
        branch_taken_i  <= branch;
        branch_target_i <= target;
        length_i        <= fetch_pkg::len_t'($urandom_range(1, `FETCH_MAX_LEN));
        stall_i         <= stall;
        @(negedge clk);
        check_cycle();
    endtask

    task automatic drive_idle(input logic stall);
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, stall);
    endtask

    // stalls while waiting so the packet stays put
    task automatic wait_packet;
        int n;
        n = 0;
        while (!packet_valid_o) begin
            if (n == WAIT_LIMIT) begin
                abort_run("timeout: no valid packet arrived within 20 cycles after a redirect");
            end
            drive_idle(1'b1);
            n++;
        end
    endtask

    initial begin
        int unsigned seed_val;
        logic [2:0]  sel;
        seed_val         = $urandom(SEED);
        reset_i          = 1'b1;
        init_i           = 1'b0;
        init_addr_i      = '0;
        resteer_i        = 1'b0;
        resteer_addr_i   = '0;
        branch_taken_i   = 1'b0;
        branch_target_i  = '0;
        imem_ack_i       = 1'b0;
        imem_even_line_i = '0;
        imem_odd_line_i  = '0;
        length_i         = 4'd1;
        stall_i          = 1'b0;
        exp_addr         = '0;
        started          = 1'b0;
        redirect_q       = 1'b0;
        held_ok          = 1'b0;
        held_packet      = '0;
        held_addr        = '0;
        idle_cycles      = 0;
        consumed         = 0;

        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        // idle until the first redirect
        repeat (8) drive_idle(1'b0);

        // init, then a short run of consumes
        drive_cycle(1'b1, $urandom(), 1'b0, '0, 1'b0, '0, 1'b0);
        wait_packet();
        repeat (40) drive_idle(1'b0);

        // resteer, then a branch in the ack cycle of its request
        drive_cycle(1'b0, '0, 1'b1, $urandom(), 1'b0, '0, 1'b0);
        drive_idle(1'b1);
        check_flag(imem_ack_i, 1'b0, "ack before request returned");
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, $urandom(), 1'b0);
        wait_packet();

        // all sources at once, then resteer with branch
        drive_cycle(1'b1, $urandom(), 1'b1, $urandom(), 1'b1, $urandom(), 1'b0);
        wait_packet();
        drive_cycle(1'b0, '0, 1'b1, $urandom(), 1'b1, $urandom(), 1'b0);
        wait_packet();

        ///////////////////////////////
        // random phase
        ///////////////////////////////
        for (int c = 0; c < RAND_CYCLES; c++) begin
            if ($urandom_range(0, 49) == 0) begin
                sel = 3'($urandom_range(1, 7));
            end else begin
                sel = 3'b000;
            end
            drive_cycle(sel[2], $urandom(), sel[1], $urandom(), sel[0], $urandom(),
                        $urandom_range(0, 3) == 0);
        end

        if (consumed < MIN_CONSUMED) begin
            abort_run($sformatf("only %0d packets were consumed in the random phase", consumed));
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule
